/* verilog/execPkg.sv */
// widths, ALU/branch/select encodings, trap op, privilege and exception codes
package execPkg;

    localparam int xlen = 32;
    localparam int shamtWidth = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [11:0] csrAddr_t;

    // step from pc to the sequential pc
    localparam word_t insnSize = 4;

    typedef enum logic [3:0] {
        AluAdd    = 4'd0,
        AluSub    = 4'd1,
        AluSll    = 4'd2,
        AluSlt    = 4'd3,
        AluSltu   = 4'd4,
        AluXor    = 4'd5,
        AluSrl    = 4'd6,
        AluSra    = 4'd7,
        AluOr     = 4'd8,
        AluAnd    = 4'd9,
        AluClear1 = 4'd10,
        AluClear2 = 4'd11
    } aluCmd_t;

    typedef enum logic [1:0] {
        AluSrc1Zero = 2'd0,
        AluSrc1Pc   = 2'd1,
        AluSrc1Reg  = 2'd2,
        AluSrc1Csr  = 2'd3
    } aluSrc1_t;

    typedef enum logic [1:0] {
        AluSrc2Zero = 2'd0,
        AluSrc2Imm  = 2'd1,
        AluSrc2Reg  = 2'd2,
        AluSrc2Csr  = 2'd3
    } aluSrc2_t;

    typedef enum logic [2:0] {
        BranchEqual                = 3'd0,
        BranchNotEqual             = 3'd1,
        BranchLessThan             = 3'd2,
        BranchGreaterEqual         = 3'd3,
        BranchUnsignedLessThan     = 3'd4,
        BranchUnsignedGreaterEqual = 3'd5,
        BranchAlways               = 3'd6
    } branchType_t;

    // source of the integer writeback value
    typedef enum logic [1:0] {
        WriteSrcResult = 2'd0,
        WriteSrcNextPc = 2'd1,
        WriteSrcCsr    = 2'd2
    } writeSrc_t;

    typedef enum logic {
        TrapOpEcall  = 1'b0,
        TrapOpEbreak = 1'b1
    } trapOp_t;

    typedef enum logic [1:0] {
        PrivilegeUser       = 2'd0,
        PrivilegeSupervisor = 2'd1,
        PrivilegeMachine    = 2'd3
    } privilege_t;

    // mcause values for the synchronous exceptions raised here
    typedef enum logic [3:0] {
        ExcIllegalInsn         = 4'd2,
        ExcBreakpoint          = 4'd3,
        ExcEcallFromUser       = 4'd8,
        ExcEcallFromSupervisor = 4'd9,
        ExcEcallFromMachine    = 4'd11
    } excCode_t;

endpackage

/* verilog/execControl.sv */
// execControl: trap ranking, trap return, flush request, next pc and write enables
`timescale 1ns/1ps

module execControl (
    input  logic                  opValid,
    input  execPkg::word_t        insn,
    input  logic                  isBranch,
    input  logic                  branchCond,
    input  execPkg::word_t        aluResult,
    input  execPkg::word_t        pc,
    input  logic                  csrReadEnable,
    input  logic                  csrReadIllegal,
    input  logic                  csrWriteEnable,
    input  logic                  isTrap,
    input  execPkg::trapOp_t      trapOp,
    input  logic                  isTrapReturn,
    input  logic                  trapReturnSupervisor,
    input  logic                  supervisorReturnTrap,
    input  execPkg::privilege_t   privilege,
    input  logic                  intRegWriteEnable,
    input  logic                  prevTrapValid,
    input  execPkg::excCode_t     prevTrapCause,
    input  execPkg::word_t        prevTrapValue,
    output logic                  branchTaken,
    output execPkg::word_t        nextPc,
    output logic                  flushReq,
    output logic                  csrWe,
    output logic                  bypassWriteEnable,
    output logic                  trapValid,
    output execPkg::excCode_t     trapCause,
    output execPkg::word_t        trapValue,
    output logic                  trapReturn
);
    import execPkg::*;

    logic isEcall;
    logic isEbreak;
    logic supervisorReturnFault;

    assign isEcall = isTrap && (trapOp == TrapOpEcall);
    assign isEbreak = isTrap && (trapOp == TrapOpEbreak);
    // sret while the csr file forbids it
    assign supervisorReturnFault = isTrapReturn && trapReturnSupervisor && supervisorReturnTrap;

    // fixed priority, earlier stages win
    always_comb begin
        trapValid = 1'b0;
        trapCause = excCode_t'('0);
        trapValue = '0;
        if (!opValid) begin
            trapValid = 1'b0;
        end else if (prevTrapValid) begin
            trapValid = 1'b1;
            trapCause = prevTrapCause;
            trapValue = prevTrapValue;
        end else if (csrReadEnable && csrReadIllegal) begin
            trapValid = 1'b1;
            trapCause = ExcIllegalInsn;
            trapValue = insn;
        end else if (isEcall) begin
            trapValid = 1'b1;
            unique case (privilege)
                PrivilegeMachine:    trapCause = ExcEcallFromMachine;
                PrivilegeSupervisor: trapCause = ExcEcallFromSupervisor;
                default:             trapCause = ExcEcallFromUser;
            endcase
        end else if (isEbreak) begin
            trapValid = 1'b1;
            trapCause = ExcBreakpoint;
        end else if (supervisorReturnFault) begin
            trapValid = 1'b1;
            trapCause = ExcIllegalInsn;
            trapValue = insn;
        end
    end

    assign trapReturn = opValid && isTrapReturn && !trapValid;

    assign branchTaken = isBranch && branchCond;
    // target comes straight from the alu (pc + imm or reg + imm)
    assign nextPc = branchTaken ? aluResult : pc + insnSize;

    assign flushReq = opValid && (branchTaken || csrWriteEnable || trapValid || trapReturn);

    assign csrWe = opValid && csrWriteEnable && !trapValid;
    assign bypassWriteEnable = opValid && intRegWriteEnable && !trapValid;

endmodule

/* verilog/operandSelect.sv */
// operandSelect: bypass forwarding and the two ALU source muxes
`timescale 1ns/1ps

module operandSelect (
    input  execPkg::word_t     srcValue1,
    input  execPkg::word_t     srcValue2,
    input  logic               bypassHit1,
    input  execPkg::word_t     bypassValue1,
    input  logic               bypassHit2,
    input  execPkg::word_t     bypassValue2,
    input  execPkg::word_t     pc,
    input  execPkg::word_t     imm,
    input  execPkg::word_t     csrReadValue,
    input  execPkg::aluSrc1_t  aluSrcSel1,
    input  execPkg::aluSrc2_t  aluSrcSel2,
    output execPkg::word_t     regValue1,
    output execPkg::word_t     regValue2,
    output execPkg::word_t     aluSrc1,
    output execPkg::word_t     aluSrc2
);
    import execPkg::*;

    // forwarded value beats the register file
    assign regValue1 = bypassHit1 ? bypassValue1 : srcValue1;
    assign regValue2 = bypassHit2 ? bypassValue2 : srcValue2;

    always_comb begin
        unique case (aluSrcSel1)
            AluSrc1Zero: aluSrc1 = '0;
            AluSrc1Pc:   aluSrc1 = pc;
            AluSrc1Reg:  aluSrc1 = regValue1;
            AluSrc1Csr:  aluSrc1 = csrReadValue;
            default:     aluSrc1 = '0;
        endcase
    end

    always_comb begin
        unique case (aluSrcSel2)
            AluSrc2Zero: aluSrc2 = '0;
            AluSrc2Imm:  aluSrc2 = imm;
            AluSrc2Reg:  aluSrc2 = regValue2;
            AluSrc2Csr:  aluSrc2 = csrReadValue;
            default:     aluSrc2 = '0;
        endcase
    end

endmodule

/* verilog/intAlu.sv */
// intAlu: integer ALU commands and the branch comparator
`timescale 1ns/1ps

module intAlu (
    input  execPkg::aluCmd_t     aluCmd,
    input  execPkg::word_t       aluSrc1,
    input  execPkg::word_t       aluSrc2,
    input  execPkg::branchType_t branchType,
    input  execPkg::word_t       regValue1,
    input  execPkg::word_t       regValue2,
    output execPkg::word_t       aluResult,
    output logic                 branchCond
);
    import execPkg::*;

    logic [shamtWidth-1:0] shamt;

    assign shamt = aluSrc2[shamtWidth-1:0];

    always_comb begin
        unique case (aluCmd)
            AluAdd:    aluResult = aluSrc1 + aluSrc2;
            AluSub:    aluResult = aluSrc1 - aluSrc2;
            AluSll:    aluResult = aluSrc1 << shamt;
            AluSlt:    aluResult = {{(xlen-1){1'b0}}, $signed(aluSrc1) < $signed(aluSrc2)};
            AluSltu:   aluResult = {{(xlen-1){1'b0}}, aluSrc1 < aluSrc2};
            AluXor:    aluResult = aluSrc1 ^ aluSrc2;
            AluSrl:    aluResult = aluSrc1 >> shamt;
            AluSra:    aluResult = word_t'($signed(aluSrc1) >>> shamt);
            AluOr:     aluResult = aluSrc1 | aluSrc2;
            AluAnd:    aluResult = aluSrc1 & aluSrc2;
            // csrrc style bit clears, either operand as the mask
            AluClear1: aluResult = aluSrc1 & ~aluSrc2;
            AluClear2: aluResult = ~aluSrc1 & aluSrc2;
            default:   aluResult = '0;
        endcase
    end

    // compares register operands, not the alu sources
    always_comb begin
        unique case (branchType)
            BranchEqual:                branchCond = regValue1 == regValue2;
            BranchNotEqual:             branchCond = regValue1 != regValue2;
            BranchLessThan:             branchCond = $signed(regValue1) < $signed(regValue2);
            BranchGreaterEqual:         branchCond = $signed(regValue1) >= $signed(regValue2);
            BranchUnsignedLessThan:     branchCond = regValue1 < regValue2;
            BranchUnsignedGreaterEqual: branchCond = regValue1 >= regValue2;
            BranchAlways:               branchCond = 1'b1;
            default:                    branchCond = 1'b0;
        endcase
    end

endmodule

/* verilog/exStageReg.sv */
// exStageReg: writeback value select and the register toward the memory stage
`timescale 1ns/1ps

module exStageReg (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 opValid,
    input  execPkg::word_t       pc,
    input  execPkg::regAddr_t    dstRegAddr,
    input  execPkg::writeSrc_t   writeSrc,
    input  logic                 intRegWriteEnable,
    input  execPkg::word_t       aluResult,
    input  execPkg::word_t       csrReadValue,
    input  logic                 branchTaken,
    input  logic                 trapValid,
    input  execPkg::excCode_t    trapCause,
    input  execPkg::word_t       trapValue,
    input  logic                 trapReturn,
    output execPkg::word_t       dstValue,
    output logic                 exValid,
    output execPkg::word_t       exPc,
    output execPkg::regAddr_t    exDstRegAddr,
    output execPkg::word_t       exDstValue,
    output logic                 exIntRegWriteEnable,
    output logic                 exBranchTaken,
    output execPkg::word_t       exBranchTarget,
    output logic                 exTrapValid,
    output execPkg::excCode_t    exTrapCause,
    output execPkg::word_t       exTrapValue,
    output logic                 exTrapReturn
);
    import execPkg::*;

    // link value for jal/jalr comes from pc + 4
    always_comb begin
        unique case (writeSrc)
            WriteSrcResult: dstValue = aluResult;
            WriteSrcNextPc: dstValue = pc + insnSize;
            WriteSrcCsr:    dstValue = csrReadValue;
            default:        dstValue = '0;
        endcase
    end

    // control bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
            exIntRegWriteEnable <= 1'b0;
            exBranchTaken <= 1'b0;
            exTrapValid <= 1'b0;
            exTrapReturn <= 1'b0;
        end else begin
            exValid <= opValid;
            exIntRegWriteEnable <= intRegWriteEnable;
            exBranchTaken <= branchTaken;
            exTrapValid <= trapValid;
            exTrapReturn <= trapReturn;
        end
    end

    // payload, qualified by the control bits above
    always_ff @(posedge clk) begin
        exPc <= pc;
        exDstRegAddr <= dstRegAddr;
        exDstValue <= dstValue;
        exBranchTarget <= aluResult;
        exTrapCause <= trapCause;
        exTrapValue <= trapValue;
    end

endmodule

/* verilog/executeStage.sv */
// executeStage: integer execute stage top built from control, operand, ALU and register blocks
`timescale 1ns/1ps

module executeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  opValid,
    input  execPkg::word_t        pc,
    input  execPkg::word_t        insn,
    input  execPkg::word_t        imm,
    input  execPkg::regAddr_t     srcRegAddr1,
    input  execPkg::regAddr_t     srcRegAddr2,
    input  execPkg::regAddr_t     dstRegAddr,
    input  execPkg::csrAddr_t     csrAddr,
    input  execPkg::word_t        srcValue1,
    input  execPkg::word_t        srcValue2,
    input  execPkg::aluCmd_t      aluCmd,
    input  execPkg::aluSrc1_t     aluSrcSel1,
    input  execPkg::aluSrc2_t     aluSrcSel2,
    input  logic                  isBranch,
    input  execPkg::branchType_t  branchType,
    input  execPkg::writeSrc_t    writeSrc,
    input  logic                  intRegWriteEnable,
    input  logic                  csrReadEnable,
    input  logic                  csrWriteEnable,
    input  logic                  isTrap,
    input  execPkg::trapOp_t      trapOp,
    input  logic                  isTrapReturn,
    input  logic                  trapReturnSupervisor,
    input  logic                  prevTrapValid,
    input  execPkg::excCode_t     prevTrapCause,
    input  execPkg::word_t        prevTrapValue,
    input  logic                  bypassHit1,
    input  execPkg::word_t        bypassValue1,
    input  logic                  bypassHit2,
    input  execPkg::word_t        bypassValue2,
    input  execPkg::word_t        csrReadValue,
    input  logic                  csrReadIllegal,
    input  execPkg::privilege_t   privilege,
    input  logic                  supervisorReturnTrap,
    output logic                  csrWe,
    output execPkg::csrAddr_t     csrWriteAddr,
    output execPkg::word_t        csrWriteValue,
    output logic                  bypassWriteEnable,
    output execPkg::regAddr_t     bypassWriteAddr,
    output execPkg::word_t        bypassWriteValue,
    output logic                  flushReq,
    output execPkg::word_t        nextPc,
    output logic                  exValid,
    output execPkg::word_t        exPc,
    output execPkg::regAddr_t     exDstRegAddr,
    output execPkg::word_t        exDstValue,
    output logic                  exIntRegWriteEnable,
    output logic                  exBranchTaken,
    output execPkg::word_t        exBranchTarget,
    output logic                  exTrapValid,
    output execPkg::excCode_t     exTrapCause,
    output execPkg::word_t        exTrapValue,
    output logic                  exTrapReturn
);
    import execPkg::*;

    word_t    regValue1;
    word_t    regValue2;
    word_t    aluSrc1;
    word_t    aluSrc2;
    word_t    aluResult;
    logic     branchCond;
    logic     branchTaken;
    logic     trapValid;
    excCode_t trapCause;
    word_t    trapValue;
    logic     trapReturn;

    assign csrWriteAddr = csrAddr;
    assign csrWriteValue = aluResult;
    assign bypassWriteAddr = dstRegAddr;

    operandSelect uOperandSelect (
        .srcValue1(srcValue1), .srcValue2(srcValue2),
        .bypassHit1(bypassHit1), .bypassValue1(bypassValue1),
        .bypassHit2(bypassHit2), .bypassValue2(bypassValue2),
        .pc(pc), .imm(imm), .csrReadValue(csrReadValue),
        .aluSrcSel1(aluSrcSel1), .aluSrcSel2(aluSrcSel2),
        .regValue1(regValue1), .regValue2(regValue2),
        .aluSrc1(aluSrc1), .aluSrc2(aluSrc2)
    );

    intAlu uIntAlu (
        .aluCmd(aluCmd), .aluSrc1(aluSrc1), .aluSrc2(aluSrc2),
        .branchType(branchType), .regValue1(regValue1), .regValue2(regValue2),
        .aluResult(aluResult), .branchCond(branchCond)
    );

    execControl uExecControl (
        .opValid(opValid), .insn(insn), .isBranch(isBranch), .branchCond(branchCond),
        .aluResult(aluResult), .pc(pc),
        .csrReadEnable(csrReadEnable), .csrReadIllegal(csrReadIllegal),
        .csrWriteEnable(csrWriteEnable), .isTrap(isTrap), .trapOp(trapOp),
        .isTrapReturn(isTrapReturn), .trapReturnSupervisor(trapReturnSupervisor),
        .supervisorReturnTrap(supervisorReturnTrap), .privilege(privilege),
        .intRegWriteEnable(intRegWriteEnable), .prevTrapValid(prevTrapValid),
        .prevTrapCause(prevTrapCause), .prevTrapValue(prevTrapValue),
        .branchTaken(branchTaken), .nextPc(nextPc), .flushReq(flushReq), .csrWe(csrWe),
        .bypassWriteEnable(bypassWriteEnable), .trapValid(trapValid),
        .trapCause(trapCause), .trapValue(trapValue), .trapReturn(trapReturn)
    );

    exStageReg uExStageReg (
        .clk(clk), .rstN(rstN), .opValid(opValid), .pc(pc), .dstRegAddr(dstRegAddr),
        .writeSrc(writeSrc), .intRegWriteEnable(intRegWriteEnable),
        .aluResult(aluResult), .csrReadValue(csrReadValue), .branchTaken(branchTaken),
        .trapValid(trapValid), .trapCause(trapCause), .trapValue(trapValue),
        .trapReturn(trapReturn), .dstValue(bypassWriteValue),
        .exValid(exValid), .exPc(exPc), .exDstRegAddr(exDstRegAddr),
        .exDstValue(exDstValue), .exIntRegWriteEnable(exIntRegWriteEnable),
        .exBranchTaken(exBranchTaken), .exBranchTarget(exBranchTarget),
        .exTrapValid(exTrapValid), .exTrapCause(exTrapCause),
        .exTrapValue(exTrapValue), .exTrapReturn(exTrapReturn)
    );

endmodule

/* test/executeStage_chk.sv */
// bound assertions for results, branches, traps, write enables, write ports, stage register and reset
`timescale 1ns/1ps

module executeStageChk (
    input logic clk, rstN, opValid, isBranch, intRegWriteEnable,
    input execPkg::word_t pc, insn, imm, srcValue1, srcValue2, bypassValue1, bypassValue2,
    input logic bypassHit1, bypassHit2, csrReadEnable, csrReadIllegal, csrWriteEnable,
    input execPkg::aluCmd_t aluCmd,
    input execPkg::aluSrc1_t aluSrcSel1,
    input execPkg::aluSrc2_t aluSrcSel2,
    input execPkg::branchType_t branchType,
    input execPkg::writeSrc_t writeSrc,
    input logic isTrap, isTrapReturn, trapReturnSupervisor, supervisorReturnTrap,
    input execPkg::trapOp_t trapOp,
    input execPkg::privilege_t privilege,
    input logic prevTrapValid,
    input execPkg::excCode_t prevTrapCause,
    input execPkg::word_t prevTrapValue, csrReadValue, nextPc, exDstValue, exBranchTarget,
    input execPkg::word_t exTrapValue,
    input execPkg::csrAddr_t csrAddr, csrWriteAddr,
    input execPkg::regAddr_t dstRegAddr, bypassWriteAddr, exDstRegAddr,
    input execPkg::word_t csrWriteValue, bypassWriteValue, exPc,
    input logic csrWe, bypassWriteEnable, flushReq, exValid, exIntRegWriteEnable,
    input logic exBranchTaken, exTrapValid, exTrapReturn,
    input execPkg::excCode_t exTrapCause
);
    import execPkg::*;

    int errorCount = 0;
    word_t reg1, reg2, src1, src2, expAlu, expDst, expNextPc, expTrapValue;
    logic expCond, expTaken, expTrapValid, expTrapReturn, expFlush;
    logic [3:0] expTrapCause;
    logic [4:0] sh;

    always_comb begin
        reg1 = bypassHit1 ? bypassValue1 : srcValue1;
        reg2 = bypassHit2 ? bypassValue2 : srcValue2;
        case (aluSrcSel1)
            AluSrc1Pc:  src1 = pc;
            AluSrc1Reg: src1 = reg1;
            AluSrc1Csr: src1 = csrReadValue;
            default:    src1 = '0;
        endcase
        case (aluSrcSel2)
            AluSrc2Imm: src2 = imm;
            AluSrc2Reg: src2 = reg2;
            AluSrc2Csr: src2 = csrReadValue;
            default:    src2 = '0;
        endcase
        sh = src2[4:0];
        case (4'(aluCmd))
            4'd0:    expAlu = src1 + src2;
            4'd1:    expAlu = src1 - src2;
            4'd2:    expAlu = src1 << sh;
            4'd3:    expAlu = {31'd0, (src1[31] != src2[31]) ? src1[31] : (src1 < src2)};
            4'd4:    expAlu = {31'd0, src1 < src2};
            4'd5:    expAlu = src1 ^ src2;
            4'd6:    expAlu = src1 >> sh;
            // sign fill built from the top bit
            4'd7:    expAlu = (src1 >> sh) | ({32{src1[31]}} << (6'd32 - {1'b0, sh}));
            4'd8:    expAlu = src1 | src2;
            4'd9:    expAlu = src1 & src2;
            4'd10:   expAlu = src1 & ~src2;
            4'd11:   expAlu = ~src1 & src2;
            default: expAlu = '0;
        endcase
        case (branchType)
            BranchEqual:                expCond = reg1 == reg2;
            BranchNotEqual:             expCond = reg1 != reg2;
            BranchLessThan:             expCond = (reg1[31] != reg2[31]) ? reg1[31] : reg1 < reg2;
            BranchGreaterEqual:         expCond = (reg1[31] != reg2[31]) ? reg2[31] : reg1 >= reg2;
            BranchUnsignedLessThan:     expCond = reg1 < reg2;
            BranchUnsignedGreaterEqual: expCond = reg1 >= reg2;
            BranchAlways:               expCond = 1'b1;
            default:                    expCond = 1'b0;
        endcase
        expTaken = isBranch && expCond;
        expNextPc = expTaken ? expAlu : pc + 32'd4;
        case (writeSrc)
            WriteSrcResult: expDst = expAlu;
            WriteSrcNextPc: expDst = pc + 32'd4;
            WriteSrcCsr:    expDst = csrReadValue;
            default:        expDst = '0;
        endcase
        expTrapValid = opValid;
        expTrapCause = 4'd0;
        expTrapValue = '0;
        if (!opValid) begin
            expTrapValid = 1'b0;
        end else if (prevTrapValid) begin
            expTrapCause = 4'(prevTrapCause);
            expTrapValue = prevTrapValue;
        end else if (csrReadEnable && csrReadIllegal) begin
            expTrapCause = 4'd2;
            expTrapValue = insn;
        end else if (isTrap && trapOp == TrapOpEcall) begin
            expTrapCause = (privilege == PrivilegeMachine) ? 4'd11 :
                           (privilege == PrivilegeSupervisor) ? 4'd9 : 4'd8;
        end else if (isTrap) begin
            expTrapCause = 4'd3;
        end else if (isTrapReturn && trapReturnSupervisor && supervisorReturnTrap) begin
            expTrapCause = 4'd2;
            expTrapValue = insn;
        end else begin
            expTrapValid = 1'b0;
        end
        expTrapReturn = opValid && isTrapReturn && !expTrapValid;
        expFlush = opValid && (expTaken || csrWriteEnable || expTrapValid || expTrapReturn);
    end

    resultA: assert property (@(posedge clk) disable iff (!rstN)
        opValid |=> exDstValue == $past(expDst))
        else begin errorCount++; $error("exDstValue differs from expected"); end

    branchNowA: assert property (@(posedge clk) disable iff (!rstN)
        opValid |-> flushReq == expFlush && nextPc == expNextPc)
        else begin errorCount++; $error("flushReq or nextPc differs from expected"); end

    branchRegA: assert property (@(posedge clk) disable iff (!rstN)
        opValid |=> exBranchTaken == $past(expTaken) && exBranchTarget == $past(expAlu))
        else begin errorCount++; $error("registered branch differs from expected"); end

    trapA: assert property (@(posedge clk) disable iff (!rstN)
        opValid |=> exTrapValid == $past(expTrapValid) && exTrapReturn == $past(expTrapReturn)
            && (!exTrapValid || (4'(exTrapCause) == $past(expTrapCause)
            && exTrapValue == $past(expTrapValue))))
        else begin errorCount++; $error("trap outputs differ from expected"); end

    writeEnableA: assert property (@(posedge clk) disable iff (!rstN)
        csrWe == (opValid && csrWriteEnable && !expTrapValid)
            && bypassWriteEnable == (opValid && intRegWriteEnable && !expTrapValid))
        else begin errorCount++; $error("write enable differs from expected"); end

    writePortA: assert property (@(posedge clk) disable iff (!rstN)
        csrWriteAddr == csrAddr && csrWriteValue == expAlu
            && bypassWriteAddr == dstRegAddr && bypassWriteValue == expDst)
        else begin errorCount++; $error("csr or bypass write port differs from expected"); end

    stageRegA: assert property (@(posedge clk) disable iff (!rstN)
        1'b1 |=> exValid == $past(opValid) && exPc == $past(pc)
            && exDstRegAddr == $past(dstRegAddr)
            && exIntRegWriteEnable == $past(intRegWriteEnable))
        else begin errorCount++; $error("stage register outputs differ from expected"); end

    resetA: assert property (@(posedge clk) (!rstN || $rose(rstN)) |->
        !(exValid || exTrapValid || exBranchTaken || exTrapReturn || exIntRegWriteEnable))
        else begin errorCount++; $error("control output set during reset"); end

endmodule

/* test/executeStageTb.sv */
// clock, reset, LFSR stimulus, error monitor, timeouts and final report
`timescale 1ns/1ps

module executeStageTb;
    import execPkg::*;

    logic clk, rstN, opValid, isBranch, intRegWriteEnable, csrReadEnable, csrWriteEnable;
    logic isTrap, isTrapReturn, trapReturnSupervisor, prevTrapValid;
    logic bypassHit1, bypassHit2, csrReadIllegal, supervisorReturnTrap;
    word_t pc, insn, imm, srcValue1, srcValue2, prevTrapValue;
    word_t bypassValue1, bypassValue2, csrReadValue;
    regAddr_t srcRegAddr1, srcRegAddr2, dstRegAddr;
    csrAddr_t csrAddr;
    aluCmd_t aluCmd;
    aluSrc1_t aluSrcSel1;
    aluSrc2_t aluSrcSel2;
    branchType_t branchType;
    writeSrc_t writeSrc;
    trapOp_t trapOp;
    privilege_t privilege;
    excCode_t prevTrapCause;
    logic csrWe, bypassWriteEnable, flushReq, exValid, exIntRegWriteEnable;
    logic exBranchTaken, exTrapValid, exTrapReturn;
    csrAddr_t csrWriteAddr;
    regAddr_t bypassWriteAddr, exDstRegAddr;
    word_t csrWriteValue, bypassWriteValue, nextPc, exPc, exDstValue;
    word_t exBranchTarget, exTrapValue;
    excCode_t exTrapCause;
    logic [31:0] lfsr = 32'h9ed3;

    executeStage dut (.*);

    bind executeStage executeStageChk chk (.*);

    always #4 clk = ~clk;

    // taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic driveOp(input logic valid);
        opValid = valid;
        pc = {randBits(30), 2'b00};
        insn = randBits(32);
        imm = randBits(32);
        srcValue1 = randBits(32);
        // equal operands now and then so eq/ne branches go both ways
        srcValue2 = (randBits(2) == 0) ? srcValue1 : randBits(32);
        bypassHit1 = randBits(1) != 0;
        bypassHit2 = randBits(1) != 0;
        bypassValue1 = randBits(32);
        bypassValue2 = bypassHit1 ? bypassValue1 : randBits(32);
        csrReadValue = randBits(32);
        srcRegAddr1 = 5'(randBits(5));
        srcRegAddr2 = 5'(randBits(5));
        dstRegAddr = 5'(randBits(5));
        csrAddr = 12'(randBits(12));
        aluCmd = aluCmd_t'(4'(randBits(4)));
        aluSrcSel1 = aluSrc1_t'(2'(randBits(2)));
        aluSrcSel2 = aluSrc2_t'(2'(randBits(2)));
        isBranch = randBits(1) != 0;
        branchType = branchType_t'(3'(randBits(3)));
        writeSrc = writeSrc_t'(2'(randBits(2)));
        intRegWriteEnable = randBits(1) != 0;
        csrReadEnable = randBits(1) != 0;
        csrWriteEnable = randBits(2) == 0;
        csrReadIllegal = randBits(2) == 0;
        isTrap = randBits(2) == 0;
        trapOp = trapOp_t'(1'(randBits(1)));
        isTrapReturn = randBits(2) == 0;
        trapReturnSupervisor = randBits(1) != 0;
        supervisorReturnTrap = randBits(1) != 0;
        privilege = privilege_t'(2'(randBits(2)));
        prevTrapValid = randBits(3) == 0;
        prevTrapCause = excCode_t'(4'(randBits(4)));
        prevTrapValue = randBits(32);
    endtask

    always @(negedge clk) begin
        if (dut.chk.errorCount != 0) begin
            $display("** Error at %0t: assertion check failed", $time);
            $display("Done: errors found");
            $fatal(1, "stopping after first failed check");
        end
    end

    initial begin
        #20000;
        $display("Timeout: simulation ran past its time limit");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int timeout;
        clk = 1'b0;
        rstN = 1'b1;
        driveOp(1'b0);
        #1 rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
        for (int i = 0; i < 400; i++) begin
            @(posedge clk);
            #1 driveOp(randBits(2) != 0);
        end
        @(posedge clk);
        #1 opValid = 1'b0;
        timeout = 0;
        while (exValid && timeout < 10) begin
            @(posedge clk);
            #1 timeout++;
        end
        if (exValid) begin
            $display("Timeout: exValid still set after the pipeline drained");
            $display("Done: errors found");
            $fatal(1, "drain timeout");
        end
        @(negedge clk);
        if (dut.chk.errorCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* src.f */
verilog/execPkg.sv
verilog/execControl.sv
verilog/operandSelect.sv
verilog/intAlu.sv
verilog/exStageReg.sv
verilog/executeStage.sv
test/executeStage_chk.sv
test/executeStageTb.sv

/* Makefile */
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module executeStageTb -f src.f -o simExec

run: build
	./obj_dir/simExec +verilator+error+limit+10 > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module executeStageTb -f src.f

clean:
	rm -rf obj_dir $(LOG)
